// File: axi/axi_read_ctrl.sv
`timescale 1ns/100ps

module axi_read_ctrl #(
  parameter int vram_index_w = text_ctrl_pkg::VRAM_INDEX_W
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  input  text_ctrl_pkg::axi_addr_t      s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output text_ctrl_pkg::axi_data_t      s_axi_rdata,
  output text_ctrl_pkg::axi_resp_t      s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  output logic [vram_index_w-1:0]       vram_rd_index,
  output text_ctrl_pkg::palette_index_t pal_rd_index,
  input  text_ctrl_pkg::axi_data_t      vram_rd_data,
  input  text_ctrl_pkg::axi_data_t      pal_rd_data
);
  import text_ctrl_pkg::*;

  logic      accept;
  logic      arready_q;
  logic      wait_q;
  logic      rvalid_q;
  axi_addr_t araddr_q;
  axi_data_t rdata_q;

  // --------------------------------------------------
  // read sequence
  // --------------------------------------------------
  // idle means no ready pulse, no wait step and no data pending
  assign accept = s_axi_arvalid && !arready_q && !wait_q && !rvalid_q;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready_q <= 1'b0;
      wait_q    <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      arready_q <= accept;
      // video memory registers its word during this step
      wait_q    <= arready_q;
      if (wait_q)
        rvalid_q <= 1'b1;
      else if (rvalid_q && s_axi_rready)
        rvalid_q <= 1'b0;
    end
  end

  // address held for the whole transfer
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      araddr_q <= s_axi_araddr;
  end

  // pick palette or video word on the second edge after accept
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wait_q)
      rdata_q <= araddr_q[PALETTE_SEL_BIT] ? pal_rd_data : vram_rd_data;
  end

  assign vram_rd_index = araddr_q[WORD_LSB +: vram_index_w];
  assign pal_rd_index  = araddr_q[WORD_LSB +: $bits(palette_index_t)];

  assign s_axi_arready = arready_q;
  assign s_axi_rvalid  = rvalid_q;
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = RESP_OKAY;

endmodule

// File: axi/axi_write_ctrl.sv
`timescale 1ns/100ps

module axi_write_ctrl #(
  parameter int vram_index_w = text_ctrl_pkg::VRAM_INDEX_W
) (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  input  text_ctrl_pkg::axi_addr_t      s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  text_ctrl_pkg::axi_data_t      s_axi_wdata,
  input  text_ctrl_pkg::axi_strb_t      s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output text_ctrl_pkg::axi_resp_t      s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  output logic                          pal_wr_en,
  output text_ctrl_pkg::palette_index_t pal_wr_index,
  output logic                          vram_wr_en,
  output logic [vram_index_w-1:0]       vram_wr_index,
  output text_ctrl_pkg::axi_strb_t      wr_strb,
  output text_ctrl_pkg::axi_data_t      wr_data
);
  import text_ctrl_pkg::*;

  logic      aw_en;
  logic      accept;
  logic      commit_q;
  logic      bvalid_q;
  logic      pal_sel;
  axi_addr_t awaddr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;

  // --------------------------------------------------
  // handshake control
  // --------------------------------------------------
  // take a write only with both valids and no response pending
  assign accept = aw_en && s_axi_awvalid && s_axi_wvalid;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      aw_en    <= 1'b1;
      commit_q <= 1'b0;
      bvalid_q <= 1'b0;
    end
    else
    begin
      // ready pulse lasts exactly one cycle, the commit cycle
      commit_q <= accept;
      // blocked until the B handshake finishes
      if (accept)
        aw_en <= 1'b0;
      else if (bvalid_q && s_axi_bready)
        aw_en <= 1'b1;
      // response rises at the end of the commit cycle
      if (commit_q)
        bvalid_q <= 1'b1;
      else if (bvalid_q && s_axi_bready)
        bvalid_q <= 1'b0;
    end
  end

  // address, data and strobes captured together on accept
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
    begin
      awaddr_q <= s_axi_awaddr;
      wdata_q  <= s_axi_wdata;
      wstrb_q  <= s_axi_wstrb;
    end
  end

  // --------------------------------------------------
  // target decode
  // --------------------------------------------------
  assign pal_sel       = awaddr_q[PALETTE_SEL_BIT];
  assign pal_wr_en     = commit_q && pal_sel;
  assign vram_wr_en    = commit_q && !pal_sel;
  assign pal_wr_index  = awaddr_q[WORD_LSB +: $bits(palette_index_t)];
  assign vram_wr_index = awaddr_q[WORD_LSB +: vram_index_w];
  assign wr_strb       = wstrb_q;
  assign wr_data       = wdata_q;

  // both readies come from the same pulse
  assign s_axi_awready = commit_q;
  assign s_axi_wready  = commit_q;
  assign s_axi_bvalid  = bvalid_q;
  assign s_axi_bresp   = RESP_OKAY;

endmodule

// File: common/text_ctrl_pkg.sv
package text_ctrl_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int AXI_ADDR_W = 16;
  localparam int AXI_DATA_W = 32;

  // byte address, data word and one strobe bit per byte lane
  typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [1:0]              axi_resp_t;

  // only OKAY is ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  // bit 13 clear selects video memory, set selects palette
  localparam int PALETTE_SEL_BIT = 13;

  // first address bit above the byte offset
  localparam int WORD_LSB = 2;

  // eight palette words, indexed by address bits 4..2
  localparam int PALETTE_WORDS = 8;
  typedef logic [$clog2(PALETTE_WORDS)-1:0] palette_index_t;

  // default video memory depth is 2**11 words
  localparam int VRAM_INDEX_W = 11;

endpackage

// File: rtl/palette_regs.sv
`timescale 1ns/100ps

module palette_regs (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  input  logic                          wr_en,
  input  text_ctrl_pkg::palette_index_t wr_index,
  input  text_ctrl_pkg::axi_strb_t      wr_strb,
  input  text_ctrl_pkg::axi_data_t      wr_data,
  input  text_ctrl_pkg::palette_index_t rd_index,
  output text_ctrl_pkg::axi_data_t      rd_data,
  output text_ctrl_pkg::axi_data_t      colors [text_ctrl_pkg::PALETTE_WORDS]
);
  import text_ctrl_pkg::*;

  localparam int lanes = $bits(axi_strb_t);

  axi_data_t words [PALETTE_WORDS];

  // --------------------------------------------------
  // palette storage
  // --------------------------------------------------
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      // all colours black after reset
      for (int i = 0; i < PALETTE_WORDS; i++)
      begin
        words[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      // only strobed byte lanes change
      for (int b = 0; b < lanes; b++)
      begin
        if (wr_strb[b])
          words[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

  // bus read, registered later by the read controller
  assign rd_data = words[rd_index];

  // display sees every word at once
  assign colors = words;

endmodule

// File: rtl/text_ctrl_axi.sv
`timescale 1ns/100ps

module text_ctrl_axi #(
  parameter int vram_index_w = text_ctrl_pkg::VRAM_INDEX_W
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // write address, data and response
  input  text_ctrl_pkg::axi_addr_t s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  text_ctrl_pkg::axi_data_t s_axi_wdata,
  input  text_ctrl_pkg::axi_strb_t s_axi_wstrb,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  output text_ctrl_pkg::axi_resp_t s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  // read address and data
  input  text_ctrl_pkg::axi_addr_t s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  output text_ctrl_pkg::axi_data_t s_axi_rdata,
  output text_ctrl_pkg::axi_resp_t s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  // display side
  input  logic [vram_index_w-1:0]  glyph_index,
  output text_ctrl_pkg::axi_data_t glyph_word,
  output text_ctrl_pkg::axi_data_t palette_colors [text_ctrl_pkg::PALETTE_WORDS]
);
  import text_ctrl_pkg::*;

  // write commit into storage
  logic                    pal_wr_en;
  palette_index_t          pal_wr_index;
  logic                    vram_wr_en;
  logic [vram_index_w-1:0] vram_wr_index;
  axi_strb_t               wr_strb;
  axi_data_t               wr_data;

  // read result path
  logic [vram_index_w-1:0] vram_rd_index;
  palette_index_t          pal_rd_index;
  axi_data_t               vram_rd_data;
  axi_data_t               pal_rd_data;

  // --------------------------------------------------
  // bus controllers
  // --------------------------------------------------
  axi_write_ctrl #(
    .vram_index_w (vram_index_w)
  ) i_axi_write_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .pal_wr_en     (pal_wr_en),
    .pal_wr_index  (pal_wr_index),
    .vram_wr_en    (vram_wr_en),
    .vram_wr_index (vram_wr_index),
    .wr_strb       (wr_strb),
    .wr_data       (wr_data)
  );

  axi_read_ctrl #(
    .vram_index_w (vram_index_w)
  ) i_axi_read_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .vram_rd_index (vram_rd_index),
    .pal_rd_index  (pal_rd_index),
    .vram_rd_data  (vram_rd_data),
    .pal_rd_data   (pal_rd_data)
  );

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  palette_regs i_palette_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (pal_wr_en),
    .wr_index      (pal_wr_index),
    .wr_strb       (wr_strb),
    .wr_data       (wr_data),
    .rd_index      (pal_rd_index),
    .rd_data       (pal_rd_data),
    .colors        (palette_colors)
  );

  text_vram #(
    .vram_index_w (vram_index_w)
  ) i_text_vram (
    .S_AXI_ACLK  (S_AXI_ACLK),
    .wr_en       (vram_wr_en),
    .wr_index    (vram_wr_index),
    .wr_strb     (wr_strb),
    .wr_data     (wr_data),
    .rd_index    (vram_rd_index),
    .rd_data     (vram_rd_data),
    .glyph_index (glyph_index),
    .glyph_word  (glyph_word)
  );

endmodule

// File: tb.f
+incdir+test
common/text_ctrl_pkg.sv
axi/axi_write_ctrl.sv
axi/axi_read_ctrl.sv
rtl/palette_regs.sv
vram/text_vram.sv
rtl/text_ctrl_axi.sv
test/tb_text_ctrl_axi.sv

// File: test/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// --------------------------------------------------
// single AXI4-Lite write with address and data together
// --------------------------------------------------
task automatic write_word(input axi_addr_t addr, input axi_data_t data,
                          input axi_strb_t strb);
  int waited;
  int hold;
  @(negedge S_AXI_ACLK);
  s_axi_awaddr  = addr;
  s_axi_awvalid = 1'b1;
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_wvalid  = 1'b1;
  // wait for the commit cycle
  waited = 0;
  @(negedge S_AXI_ACLK);
  while (!s_axi_awready)
  begin
    waited++;
    if (waited > timeout_cycles)
      report_timeout("AWREADY after a write address");
    @(negedge S_AXI_ACLK);
  end
  // both readies pulse in the same cycle
  check_flag("s_axi_wready", s_axi_wready, 1'b1);
  s_axi_awvalid = 1'b0;
  s_axi_wvalid  = 1'b0;
  waited = 0;
  while (!s_axi_bvalid)
  begin
    waited++;
    if (waited > timeout_cycles)
      report_timeout("BVALID after the write commit");
    @(negedge S_AXI_ACLK);
  end
  // ready pulse lasted a single cycle
  check_flag("s_axi_awready", s_axi_awready, 1'b0);
  check_flag("s_axi_wready", s_axi_wready, 1'b0);
  check_resp("s_axi_bresp", s_axi_bresp, RESP_OKAY);
  // response holds while a slow master keeps BREADY low
  hold = {$random(seed)} % 5;
  repeat (hold)
  begin
    @(negedge S_AXI_ACLK);
    check_flag("s_axi_bvalid", s_axi_bvalid, 1'b1);
    check_resp("s_axi_bresp", s_axi_bresp, RESP_OKAY);
  end
  s_axi_bready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_bready = 1'b0;
  // one response per write
  check_flag("s_axi_bvalid", s_axi_bvalid, 1'b0);
endtask

// --------------------------------------------------
// single AXI4-Lite read
// --------------------------------------------------
task automatic read_word(input axi_addr_t addr, output axi_data_t data);
  int waited;
  int hold;
  @(negedge S_AXI_ACLK);
  s_axi_araddr  = addr;
  s_axi_arvalid = 1'b1;
  waited = 0;
  @(negedge S_AXI_ACLK);
  while (!s_axi_arready)
  begin
    waited++;
    if (waited > timeout_cycles)
      report_timeout("ARREADY after a read address");
    @(negedge S_AXI_ACLK);
  end
  s_axi_arvalid = 1'b0;
  waited = 0;
  while (!s_axi_rvalid)
  begin
    waited++;
    if (waited > timeout_cycles)
      report_timeout("RVALID after the read address handshake");
    @(negedge S_AXI_ACLK);
  end
  // address ready pulsed only once
  check_flag("s_axi_arready", s_axi_arready, 1'b0);
  data = s_axi_rdata;
  check_resp("s_axi_rresp", s_axi_rresp, RESP_OKAY);
  // rdata must not move while RREADY is low
  hold = {$random(seed)} % 5;
  repeat (hold)
  begin
    @(negedge S_AXI_ACLK);
    check_flag("s_axi_rvalid", s_axi_rvalid, 1'b1);
    check_data("s_axi_rdata", s_axi_rdata, data);
  end
  s_axi_rready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_rready = 1'b0;
  check_flag("s_axi_rvalid", s_axi_rvalid, 1'b0);
endtask

`endif

// File: test/tb_text_ctrl_axi.sv
`timescale 1ns/100ps

module tb_text_ctrl_axi;
  import text_ctrl_pkg::*;

  localparam int vram_w         = VRAM_INDEX_W;
  localparam int vram_depth     = 2 ** vram_w;
  localparam int timeout_cycles = 20;
  localparam int num_ops        = 400;

  logic      S_AXI_ACLK;
  logic      S_AXI_ARESETN;
  axi_addr_t s_axi_awaddr;
  logic      s_axi_awvalid;
  logic      s_axi_awready;
  axi_data_t s_axi_wdata;
  axi_strb_t s_axi_wstrb;
  logic      s_axi_wvalid;
  logic      s_axi_wready;
  axi_resp_t s_axi_bresp;
  logic      s_axi_bvalid;
  logic      s_axi_bready;
  axi_addr_t s_axi_araddr;
  logic      s_axi_arvalid;
  logic      s_axi_arready;
  axi_data_t s_axi_rdata;
  axi_resp_t s_axi_rresp;
  logic      s_axi_rvalid;
  logic      s_axi_rready;
  logic [vram_w-1:0] glyph_index;
  axi_data_t glyph_word;
  axi_data_t palette_colors [PALETTE_WORDS];

  integer seed;

  // reference model of both targets
  axi_data_t model_pal [PALETTE_WORDS];
  axi_data_t model_vram [vram_depth];
  bit        vram_written [vram_depth];
  int        written_list [$];

  text_ctrl_axi #(
    .vram_index_w (vram_w)
  ) i_text_ctrl_axi (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .S_AXI_ARESETN  (S_AXI_ARESETN),
    .s_axi_awaddr   (s_axi_awaddr),
    .s_axi_awvalid  (s_axi_awvalid),
    .s_axi_awready  (s_axi_awready),
    .s_axi_wdata    (s_axi_wdata),
    .s_axi_wstrb    (s_axi_wstrb),
    .s_axi_wvalid   (s_axi_wvalid),
    .s_axi_wready   (s_axi_wready),
    .s_axi_bresp    (s_axi_bresp),
    .s_axi_bvalid   (s_axi_bvalid),
    .s_axi_bready   (s_axi_bready),
    .s_axi_araddr   (s_axi_araddr),
    .s_axi_arvalid  (s_axi_arvalid),
    .s_axi_arready  (s_axi_arready),
    .s_axi_rdata    (s_axi_rdata),
    .s_axi_rresp    (s_axi_rresp),
    .s_axi_rvalid   (s_axi_rvalid),
    .s_axi_rready   (s_axi_rready),
    .glyph_index    (glyph_index),
    .glyph_word     (glyph_word),
    .palette_colors (palette_colors)
  );

  // 40 ns clock
  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, timeout_cycles);
    abort_run();
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input axi_data_t actual,
                            input axi_data_t expected);
    if (actual !== expected)
    begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t actual,
                            input axi_resp_t expected);
    if (actual !== expected)
    begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // every colour output against the model palette
  task automatic check_palette();
    for (int i = 0; i < PALETTE_WORDS; i++)
    begin
      if (palette_colors[i] !== model_pal[i])
      begin
        $display("** Error: palette_colors[%0d] = 0x%08h, expected 0x%08h",
                 i, palette_colors[i], model_pal[i]);
        abort_run();
      end
    end
  endtask

  `include "tb_axi_tasks.svh"

  // --------------------------------------------------
  // model helpers
  // --------------------------------------------------
  // strobed lanes take new data, others keep old
  function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                            input axi_data_t new_word,
                                            input axi_strb_t strb);
    axi_data_t result;
    result = old_word;
    for (int b = 0; b < $bits(axi_strb_t); b++)
    begin
      if (strb[b])
        result[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return result;
  endfunction

  // unused address bits carry random noise
  function automatic axi_addr_t palette_addr(input palette_index_t idx, input axi_addr_t noise);
    axi_addr_t a;
    a = noise;
    a[PALETTE_SEL_BIT] = 1'b1;
    a[WORD_LSB +: $bits(palette_index_t)] = idx;
    return a;
  endfunction

  function automatic axi_addr_t vram_addr(input logic [vram_w-1:0] idx, input axi_addr_t noise);
    axi_addr_t a;
    a = noise;
    a[PALETTE_SEL_BIT] = 1'b0;
    a[WORD_LSB +: vram_w] = idx;
    return a;
  endfunction

  // --------------------------------------------------
  // random sequence
  // --------------------------------------------------
  initial
  begin
    int                op;
    palette_index_t    pidx;
    logic [vram_w-1:0] vidx;
    axi_data_t         data;
    axi_strb_t         strb;
    axi_data_t         got;
    seed          = 32'h775bd8d4;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    glyph_index   = '0;
    for (int i = 0; i < PALETTE_WORDS; i++)
      model_pal[i] = '0;
    repeat (5) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);
    // idle handshakes and black palette out of reset
    check_flag("s_axi_awready", s_axi_awready, 1'b0);
    check_flag("s_axi_wready", s_axi_wready, 1'b0);
    check_flag("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_flag("s_axi_arready", s_axi_arready, 1'b0);
    check_flag("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_palette();
    for (int n = 0; n < num_ops; n++)
    begin
      op = {$random(seed)} % 5;
      case (op)
        0:
        begin
          pidx = $random(seed);
          data = $random(seed);
          strb = $random(seed);
          write_word(palette_addr(pidx, $random(seed)), data, strb);
          model_pal[pidx] = merge_bytes(model_pal[pidx], data, strb);
          check_palette();
        end
        1:
        begin
          // half the time overwrite a known word to test the merge
          if (written_list.size() > 0 && $random(seed) % 2 == 0)
            vidx = written_list[{$random(seed)} % written_list.size()];
          else
            vidx = $random(seed);
          data = $random(seed);
          strb = $random(seed);
          write_word(vram_addr(vidx, $random(seed)), data, strb);
          model_vram[vidx] = merge_bytes(model_vram[vidx], data, strb);
          if (!vram_written[vidx])
          begin
            vram_written[vidx] = 1'b1;
            written_list.push_back(vidx);
          end
        end
        2:
        begin
          pidx = $random(seed);
          read_word(palette_addr(pidx, $random(seed)), got);
          check_data("s_axi_rdata", got, model_pal[pidx]);
        end
        3:
        begin
          if (written_list.size() > 0)
          begin
            vidx = written_list[{$random(seed)} % written_list.size()];
            read_word(vram_addr(vidx, $random(seed)), got);
            check_data("s_axi_rdata", got, model_vram[vidx]);
          end
        end
        default:
        begin
          // display port, word due one cycle later
          if (written_list.size() > 0)
          begin
            vidx = written_list[{$random(seed)} % written_list.size()];
            @(negedge S_AXI_ACLK);
            glyph_index = vidx;
            @(negedge S_AXI_ACLK);
            check_data("glyph_word", glyph_word, model_vram[vidx]);
          end
        end
      endcase
    end
    $display("%0d operations, %0d video words written", num_ops, written_list.size());
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: vram/text_vram.sv
`timescale 1ns/100ps

module text_vram #(
  parameter int vram_index_w = text_ctrl_pkg::VRAM_INDEX_W
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     wr_en,
  input  logic [vram_index_w-1:0]  wr_index,
  input  text_ctrl_pkg::axi_strb_t wr_strb,
  input  text_ctrl_pkg::axi_data_t wr_data,
  input  logic [vram_index_w-1:0]  rd_index,
  output text_ctrl_pkg::axi_data_t rd_data,
  input  logic [vram_index_w-1:0]  glyph_index,
  output text_ctrl_pkg::axi_data_t glyph_word
);
  import text_ctrl_pkg::*;

  localparam int depth = 2 ** vram_index_w;
  localparam int lanes = $bits(axi_strb_t);

  // one word per character cell
  axi_data_t mem [depth];

  // --------------------------------------------------
  // bus write port
  // --------------------------------------------------
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < lanes; b++)
      begin
        if (wr_strb[b])
          mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

  // --------------------------------------------------
  // read ports, one cycle latency each
  // --------------------------------------------------
  // bus side, old data on a same-cycle write
  always_ff @(posedge S_AXI_ACLK)
  begin
    rd_data <= mem[rd_index];
  end

  // display side
  always_ff @(posedge S_AXI_ACLK)
  begin
    glyph_word <= mem[glyph_index];
  end

endmodule
